// File: source/router_consts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

////////////////////////////////////////
// Bus and address widths
////////////////////////////////////////

// Only the low address bits reach the decoder
`define ROUTER_ADDR_W        16
`define ROUTER_DATA_W        32
`define ROUTER_WORD_IDX_W    12
`define ROUTER_REG_IDX_W     3
`define ROUTER_WBEN_W        4

////////////////////////////////////////
// Transfer codes
////////////////////////////////////////

`define ROUTER_HTRANS_W      2
`define ROUTER_HTRANS_NONSEQ 2'b10
`define ROUTER_SIZE_W        3

`endif

// File: source/bus_pkg.sv
`default_nettype none

`include "router_consts.svh"

package bus_pkg;

    ////////////////////////////////////////
    // Core side request
    ////////////////////////////////////////

    // Transfer size as the core encodes it
    typedef enum logic [`ROUTER_SIZE_W-1:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    // One port's request, write data rides along
    typedef struct packed {
        logic [`ROUTER_HTRANS_W-1:0] htrans;
        logic                        hwrite;
        hsize_e                      hsize;
        logic [`ROUTER_ADDR_W-1:0]   haddr;
        logic [`ROUTER_DATA_W-1:0]   hwdata;
    } bus_req_t;

    ////////////////////////////////////////
    // Address views
    ////////////////////////////////////////

    // RAM view of the address
    typedef struct packed {
        logic [1:0]                    region;
        logic [`ROUTER_WORD_IDX_W-1:0] word_idx;
        logic [1:0]                    byte_off;
    } mem_addr_t;

    // Register block view, index sits just above the byte offset
    typedef struct packed {
        logic                         is_reg;
        logic [9:0]                   unused;
        logic [`ROUTER_REG_IDX_W-1:0] reg_idx;
        logic [1:0]                   byte_off;
    } reg_addr_t;

    // Same address word, two readings
    typedef union packed {
        mem_addr_t mem;
        reg_addr_t regs;
    } bus_addr_u;

endpackage

`default_nettype wire

// File: source/target_pkg.sv
`default_nettype none

`include "router_consts.svh"

package target_pkg;

    // Target selected by address bits 15:14
    typedef enum logic [1:0] {
        TGT_INST = 2'd0,
        TGT_DATA = 2'd1,
        TGT_REG  = 2'd2
    } target_e;

    // What a slave sees for one transfer
    typedef struct packed {
        logic                          active;
        logic                          rwn;
        logic [`ROUTER_WORD_IDX_W-1:0] idx;
        logic [`ROUTER_WBEN_W-1:0]     wben;
        logic [`ROUTER_DATA_W-1:0]     wdata;
    } slave_req_t;

    // Decoder output toward the arbiter
    typedef struct packed {
        logic       valid;
        target_e    target;
        slave_req_t payload;
    } decoded_req_t;

    // Read words coming back, one per target
    typedef struct packed {
        logic [`ROUTER_DATA_W-1:0] inst;
        logic [`ROUTER_DATA_W-1:0] data;
        logic [`ROUTER_DATA_W-1:0] regs;
    } slave_rdata_t;

endpackage

`default_nettype wire

// File: source/port_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_consts.svh"

module port_decoder
    import bus_pkg::*;
    import target_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  bus_req_t                  req,
    input  logic                      grant,
    input  slave_rdata_t              rdata,
    output decoded_req_t              dec,
    output logic                      hready,
    output logic [`ROUTER_DATA_W-1:0] hrdata
);

    bus_addr_u                     addr_view;
    target_e                       target;
    logic [`ROUTER_WORD_IDX_W-1:0] index;
    logic [`ROUTER_WBEN_W-1:0]     lanes;
    logic                          request;
    logic                          accept;
    logic                          resp_q;
    target_e                       resp_tgt_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign addr_view = req.haddr;

    // 00 inst RAM, 01 data RAM, 1x registers
    always_comb begin
        if (addr_view.regs.is_reg) begin
            target = TGT_REG;
        end else if (addr_view.mem.region[0]) begin
            target = TGT_DATA;
        end else begin
            target = TGT_INST;
        end
    end

    // Register index is zero extended to the RAM index width
    always_comb begin
        if (addr_view.regs.is_reg) begin
            index = {{(`ROUTER_WORD_IDX_W-`ROUTER_REG_IDX_W){1'b0}}, addr_view.regs.reg_idx};
        end else begin
            index = addr_view.mem.word_idx;
        end
    end

    ////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////

    // Reads never enable a lane
    always_comb begin
        lanes = '0;
        if (req.hwrite) begin
            case (req.hsize)
                HSIZE_BYTE: begin
                    lanes = {{(`ROUTER_WBEN_W-1){1'b0}}, 1'b1} << addr_view.mem.byte_off;
                end
                HSIZE_HALF: begin
                    if (addr_view.mem.byte_off[1]) begin
                        lanes = 4'b1100;
                    end else begin
                        lanes = 4'b0011;
                    end
                end
                default: begin
                    lanes = 4'b1111;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Request toward the arbiter
    ////////////////////////////////////////

    // Held off during the response cycle so one transfer is not taken twice
    assign request = (req.htrans == `ROUTER_HTRANS_NONSEQ) && !resp_q;
    assign accept  = request && grant;

    always_comb begin
        dec.valid          = request;
        dec.target         = target;
        dec.payload.active = request;
        dec.payload.rwn    = !req.hwrite;
        dec.payload.idx    = index;
        dec.payload.wben   = lanes;
        dec.payload.wdata  = req.hwdata;
    end

    ////////////////////////////////////////
    // Response cycle
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= accept;
        end
    end

    // Remember where the read word will come from
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_tgt_q <= target;
        end
    end

    assign hready = resp_q;

    // Slaves answer asynchronously while active, so steer straight through
    always_comb begin
        case (resp_tgt_q)
            TGT_DATA: hrdata = rdata.data;
            TGT_REG:  hrdata = rdata.regs;
            default:  hrdata = rdata.inst;
        endcase
    end

endmodule

`default_nettype wire

// File: source/target_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module target_arbiter
    import target_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  decoded_req_t imem_dec,
    input  decoded_req_t dmem_dec,
    output logic         imem_grant,
    output logic         dmem_grant,
    output slave_req_t   inst_slave,
    output slave_req_t   data_slave,
    output slave_req_t   reg_slave
);

    localparam int NUM_TGT = int'(TGT_REG) + 1;

    // Inst RAM starts out favoring imem, data RAM and registers favor dmem
    localparam logic [NUM_TGT-1:0] FAVOR_RESET = 3'b001;

    logic [NUM_TGT-1:0] favor_imem;
    logic               conflict;
    logic [NUM_TGT-1:0] imem_hit;
    logic [NUM_TGT-1:0] dmem_hit;
    logic [NUM_TGT-1:0] active_q;
    slave_req_t         slave_q [NUM_TGT];

    ////////////////////////////////////////
    // Grant
    ////////////////////////////////////////

    // Both ports after the same target in this cycle
    assign conflict = imem_dec.valid && dmem_dec.valid &&
                      (imem_dec.target == dmem_dec.target);

    assign imem_grant = imem_dec.valid && (!conflict || favor_imem[imem_dec.target]);
    assign dmem_grant = dmem_dec.valid && (!conflict || !favor_imem[dmem_dec.target]);

    // Which target each granted port lands on
    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            imem_hit[t] = imem_grant && (imem_dec.target == target_e'(t));
            dmem_hit[t] = dmem_grant && (dmem_dec.target == target_e'(t));
        end
    end

    // Flip after every conflict so a held loser wins the next round
    always_ff @(posedge clk) begin
        if (reset) begin
            favor_imem <= FAVOR_RESET;
        end else if (conflict) begin
            favor_imem[imem_dec.target] <= !favor_imem[imem_dec.target];
        end
    end

    ////////////////////////////////////////
    // Slave drive
    ////////////////////////////////////////

    // One cycle strobe per accepted transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= '0;
        end else begin
            active_q <= imem_hit | dmem_hit;
        end
    end

    // Payload of the winner, held until the next transfer to that target
    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_TGT; t++) begin
            if (imem_hit[t]) begin
                slave_q[t] <= imem_dec.payload;
            end else if (dmem_hit[t]) begin
                slave_q[t] <= dmem_dec.payload;
            end
        end
    end

    // Strobe comes from the reset flops, the rest from the payload
    always_comb begin
        inst_slave        = slave_q[TGT_INST];
        inst_slave.active = active_q[TGT_INST];
    end

    always_comb begin
        data_slave        = slave_q[TGT_DATA];
        data_slave.active = active_q[TGT_DATA];
    end

    always_comb begin
        reg_slave        = slave_q[TGT_REG];
        reg_slave.active = active_q[TGT_REG];
    end

endmodule

`default_nettype wire

// File: source/router_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_consts.svh"

module router_top
    import bus_pkg::*;
    import target_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // Core side
    input  bus_req_t                  imem_req,
    input  bus_req_t                  dmem_req,
    output logic                      imem_hready,
    output logic [`ROUTER_DATA_W-1:0] imem_hrdata,
    output logic                      dmem_hready,
    output logic [`ROUTER_DATA_W-1:0] dmem_hrdata,

    // Slave side
    output slave_req_t                inst_slave,
    output slave_req_t                data_slave,
    output slave_req_t                reg_slave,
    input  slave_rdata_t              slave_rdata
);

    decoded_req_t imem_dec;
    decoded_req_t dmem_dec;
    logic         imem_grant;
    logic         dmem_grant;

    ////////////////////////////////////////
    // Port decoders
    ////////////////////////////////////////

    port_decoder u_imem_port (
        .clk    (clk),
        .reset  (reset),
        .req    (imem_req),
        .grant  (imem_grant),
        .rdata  (slave_rdata),
        .dec    (imem_dec),
        .hready (imem_hready),
        .hrdata (imem_hrdata)
    );

    port_decoder u_dmem_port (
        .clk    (clk),
        .reset  (reset),
        .req    (dmem_req),
        .grant  (dmem_grant),
        .rdata  (slave_rdata),
        .dec    (dmem_dec),
        .hready (dmem_hready),
        .hrdata (dmem_hrdata)
    );

    ////////////////////////////////////////
    // Target arbitration
    ////////////////////////////////////////

    target_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .imem_dec   (imem_dec),
        .dmem_dec   (dmem_dec),
        .imem_grant (imem_grant),
        .dmem_grant (dmem_grant),
        .inst_slave (inst_slave),
        .data_slave (data_slave),
        .reg_slave  (reg_slave)
    );

endmodule

`default_nettype wire

// File: test/router_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "router_consts.svh"

module router_tb
    import bus_pkg::*;
    import target_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int NUM_SINGLE     = 100;
    localparam int NUM_PARALLEL   = 60;
    localparam int NUM_CONFLICT   = 40;

    logic                      clk = 1'b0;
    logic                      reset = 1'b1;
    bus_req_t                  req_v [2];
    logic [1:0]                hready_v;
    logic [`ROUTER_DATA_W-1:0] hrdata_v [2];
    slave_req_t                inst_slave;
    slave_req_t                data_slave;
    slave_req_t                reg_slave;
    slave_req_t [2:0]          slaves;
    slave_rdata_t              slave_rdata;

    // Slave storage and its shadow copy
    logic [31:0] inst_mem [4096];
    logic [31:0] data_mem [4096];
    logic [31:0] reg_mem [8];
    logic [31:0] shadow [3][4096];

    // Transfer each port is expected to make
    logic        pend [2];
    int          start_cycle [2];
    int          lat [2];
    logic [1:0]  exp_tgt [2];
    logic        exp_wr [2];
    logic [11:0] exp_idx [2];
    logic [3:0]  exp_wben [2];
    logic [31:0] exp_wdata [2];
    logic [31:0] exp_rdata [2];

    logic [2:0]  favor_imem = 3'b001;
    logic [31:0] lfsr_state = 32'hac1e_eaf6;
    int          cycle_count = 0;
    logic        after_reset = 1'b0;
    logic        after_reset_q = 1'b0;

    always #4 clk = !clk;

    router_top DUT (
        .clk         (clk),
        .reset       (reset),
        .imem_req    (req_v[0]),
        .dmem_req    (req_v[1]),
        .imem_hready (hready_v[0]),
        .imem_hrdata (hrdata_v[0]),
        .dmem_hready (hready_v[1]),
        .dmem_hrdata (hrdata_v[1]),
        .inst_slave  (inst_slave),
        .data_slave  (data_slave),
        .reg_slave   (reg_slave),
        .slave_rdata (slave_rdata)
    );

    assign slaves = {reg_slave, data_slave, inst_slave};

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] fill_word(input int t, input int i);
        return 32'(((t << 12) | i) * 32'h9e37_79b9) ^ 32'h0f0f_3c3c;
    endfunction

    function automatic logic [3:0] lane_mask(input hsize_e size, input logic [1:0] off);
        case (size)
            HSIZE_BYTE: return 4'b0001 << off;
            HSIZE_HALF: return off[1] ? 4'b1100 : 4'b0011;
            default:    return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] wben);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (wben[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return word;
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////
    // Slave models
    ////////////////////////////////////////

    always_comb begin
        slave_rdata = '0;
        if (inst_slave.active && inst_slave.rwn) begin
            slave_rdata.inst = inst_mem[inst_slave.idx];
        end
        if (data_slave.active && data_slave.rwn) begin
            slave_rdata.data = data_mem[data_slave.idx];
        end
        if (reg_slave.active && reg_slave.rwn) begin
            slave_rdata.regs = reg_mem[reg_slave.idx[2:0]];
        end
    end

    always @(posedge clk) begin
        if (inst_slave.active && !inst_slave.rwn) begin
            inst_mem[inst_slave.idx] <= merge_bytes(inst_mem[inst_slave.idx],
                                                    inst_slave.wdata, inst_slave.wben);
        end
        if (data_slave.active && !data_slave.rwn) begin
            data_mem[data_slave.idx] <= merge_bytes(data_mem[data_slave.idx],
                                                    data_slave.wdata, data_slave.wben);
        end
        if (reg_slave.active && !reg_slave.rwn) begin
            reg_mem[reg_slave.idx[2:0]] <= merge_bytes(reg_mem[reg_slave.idx[2:0]],
                                                       reg_slave.wdata, reg_slave.wben);
        end
    end

    always @(posedge clk) begin
        after_reset   <= reset;
        after_reset_q <= after_reset;
        cycle_count   <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: a transfer never completed within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "stopped by timeout");
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clk) (after_reset || after_reset_q) |->
        hready_v == 2'b00 && !slaves[0].active && !slaves[1].active && !slaves[2].active)
    else report_error("hready or slave strobe high around reset");

    for (genvar p = 0; p < 2; p++) begin : g_port_check
        assert property (@(posedge clk) disable iff (reset)
            hready_v[p] == (pend[p] && (cycle_count - start_cycle[p]) == lat[p]))
        else report_error($sformatf("port %0d hready in the wrong cycle", p));

        assert property (@(posedge clk) disable iff (reset) hready_v[p] |->
            slaves[exp_tgt[p]].active && slaves[exp_tgt[p]].rwn == !exp_wr[p] &&
            slaves[exp_tgt[p]].idx == exp_idx[p] && slaves[exp_tgt[p]].wben == exp_wben[p])
        else report_error($sformatf("port %0d slave strobe, index or lanes wrong", p));

        assert property (@(posedge clk) disable iff (reset) hready_v[p] && exp_wr[p] |->
            slaves[exp_tgt[p]].wdata == exp_wdata[p])
        else report_error($sformatf("port %0d write data wrong at slave", p));

        assert property (@(posedge clk) disable iff (reset) hready_v[p] && !exp_wr[p] |->
            hrdata_v[p] == exp_rdata[p])
        else report_error($sformatf("port %0d read data mismatch", p));
    end

    // Exactly one port completes on a target per strobe
    for (genvar t = 0; t < 3; t++) begin : g_strobe_check
        assert property (@(posedge clk) disable iff (reset) slaves[t].active ==
            ((hready_v[0] && exp_tgt[0] == t) ^ (hready_v[1] && exp_tgt[1] == t)))
        else report_error($sformatf("target %0d strobe without a matching completion", t));
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic start_port(input int p, input int t, input logic wr, input logic [11:0] word);
        hsize_e      size;
        logic [1:0]  off;
        logic [11:0] idx;
        size = hsize_e'(3'(take_bits(2) % 3));
        off  = 2'(take_bits(2));
        if (size == HSIZE_HALF) begin
            off[0] = 1'b0;
        end else if (size == HSIZE_WORD) begin
            off = 2'b00;
        end
        idx = (t == 2) ? {9'd0, word[2:0]} : word;
        req_v[p].htrans = `ROUTER_HTRANS_NONSEQ;
        req_v[p].hwrite = wr;
        req_v[p].hsize  = size;
        // Register addresses carry random bits in the unused field
        req_v[p].haddr  = (t == 2) ? {1'b1, 10'(take_bits(10)), word[2:0], off}
                                   : {2'(t), word, off};
        req_v[p].hwdata = take_bits(32);
        exp_tgt[p]   = 2'(t);
        exp_wr[p]    = wr;
        exp_idx[p]   = idx;
        exp_wben[p]  = wr ? lane_mask(size, off) : 4'b0000;
        exp_wdata[p] = req_v[p].hwdata;
        exp_rdata[p] = shadow[t][idx];
        if (wr) begin
            shadow[t][idx] = merge_bytes(shadow[t][idx], req_v[p].hwdata, exp_wben[p]);
        end
        pend[p]        = 1'b1;
        start_cycle[p] = cycle_count;
        lat[p]         = 1;
    endtask

    // Hold each request until its hready is seen at a rising edge
    task automatic finish_ports();
        int st [2];
        for (int p = 0; p < 2; p++) begin
            st[p] = pend[p] ? 1 : 0;
        end
        while (st[0] != 0 || st[1] != 0) begin
            @(negedge clk);
            for (int p = 0; p < 2; p++) begin
                if (st[p] == 2) begin
                    req_v[p].htrans = '0;
                    pend[p]         = 1'b0;
                    st[p]           = 0;
                end else if (st[p] == 1 && hready_v[p]) begin
                    st[p] = 2;
                end
            end
        end
    endtask

    initial begin
        int          tgt;
        int          other;
        int          winner;
        logic [11:0] word;
        for (int p = 0; p < 2; p++) begin
            req_v[p]       = '0;
            pend[p]        = 1'b0;
            start_cycle[p] = 0;
            lat[p]         = 1;
        end
        for (int i = 0; i < 4096; i++) begin
            inst_mem[i]  = fill_word(0, i);
            data_mem[i]  = fill_word(1, i);
            shadow[0][i] = fill_word(0, i);
            shadow[1][i] = fill_word(1, i);
            shadow[2][i] = fill_word(2, i);
        end
        for (int i = 0; i < 8; i++) begin
            reg_mem[i] = fill_word(2, i);
        end
        @(negedge clk);

        // Both ports write inst RAM word 0 while reset is high
        for (int p = 0; p < 2; p++) begin
            req_v[p].htrans = `ROUTER_HTRANS_NONSEQ;
            req_v[p].hwrite = 1'b1;
            req_v[p].hsize  = HSIZE_WORD;
        end
        repeat (7) @(negedge clk);
        reset = 1'b0;
        for (int p = 0; p < 2; p++) begin
            req_v[p].htrans = '0;
        end
        repeat (2) @(negedge clk);

        // Write then read back from a random port each time
        for (int n = 0; n < NUM_SINGLE; n++) begin
            tgt  = int'(take_bits(2) % 3);
            word = 12'(take_bits(12));
            start_port(int'(take_bits(1)), tgt, 1'b1, word);
            finish_ports();
            start_port(int'(take_bits(1)), tgt, 1'b0, word);
            finish_ports();
        end

        // Different targets in the same cycle
        for (int n = 0; n < NUM_PARALLEL; n++) begin
            tgt   = int'(take_bits(2) % 3);
            other = (tgt + 1 + int'(take_bits(1))) % 3;
            start_port(0, tgt, 1'(take_bits(1)), 12'(take_bits(12)));
            start_port(1, other, 1'(take_bits(1)), 12'(take_bits(12)));
            finish_ports();
        end

        // Same target so the favor bit picks the winner and flips
        for (int n = 0; n < NUM_CONFLICT; n++) begin
            tgt = int'(take_bits(2) % 3);
            start_port(0, tgt, 1'b0, 12'(take_bits(12)));
            start_port(1, tgt, 1'b0, 12'(take_bits(12)));
            winner          = favor_imem[tgt] ? 0 : 1;
            lat[1 - winner] = 2;
            favor_imem[tgt] = !favor_imem[tgt];
            finish_ports();
        end

        repeat (2) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/bus_pkg.sv
source/target_pkg.sv
source/port_decoder.sv
source/target_arbiter.sv
source/router_top.sv
test/router_tb.sv

// File: Bender.yml
package:
  name: bus_router

sources:
  - include_dirs:
      - source
    files:
      - source/bus_pkg.sv
      - source/target_pkg.sv
      - source/port_decoder.sv
      - source/target_arbiter.sv
      - source/router_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/router_tb.sv
